// ==== bench/drum_trigger_tb.sv ====
module drum_trigger_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import drum_geom_pkg::*;
    import drum_event_pkg::*;

    localparam rate_t STRIKE_RATE = -16'sd3000; // Well below the strike threshold
    localparam rate_t REARM_RATE  = 16'sd1000;  // Above the re-arm threshold
    localparam int    HIT_LATENCY = 4;          // Gyro sample to trigger_valid, in cycles
    // Tests run for about 300 cycles
    localparam int    TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst_n;
    logic       orient_valid;
    orient_t    orient;
    logic       gyro_valid;
    gyro_t      gyro;
    logic       calibrate_pulse;
    logic       kick_pulse;
    logic       trigger_valid;
    drum_code_t trigger_code;
    logic       event_dropped;

    logic [31:0] rng_state;
    angle_t      yaw_zero;        // Expected calibration offset
    orient_t     held;            // Expected orientation inside the classifier
    int          cycle_count = 0;

    drum_trigger_top #(
        .STRIKE_THRESH (STRIKE_THRESH_DEF),
        .REARM_THRESH  (REARM_THRESH_DEF),
        .PITCH_UP      (PITCH_UP_DEF),
        .FIFO_DEPTH    (4)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .orient_valid    (orient_valid),
        .orient          (orient),
        .gyro_valid      (gyro_valid),
        .gyro            (gyro),
        .calibrate_pulse (calibrate_pulse),
        .kick_pulse      (kick_pulse),
        .trigger_valid   (trigger_valid),
        .trigger_code    (trigger_code),
        .event_dropped   (event_dropped)
    );

    always #50 clk = ~clk; // 100 ns period

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Simulation timed out after %0d cycles", cycle_count));
        end
    end

    task automatic check_code(input string test, input drum_code_t exp, input drum_code_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: expected code %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input bit exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: expected %0b, actual %0b", test, exp, act));
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("FAILED %s: expected %0d triggers, actual %0d",
                test, exp, act));
        end
    endtask

    // 32-bit xorshift, shifts 13/17/5
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] random16();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    // Drum table by yaw quadrant, pitch and twist direction
    function automatic drum_code_t expected_code(input orient_t o, input rate_t rate_z);
        logic [15:0] yaw_u;
        logic        up;
        yaw_u = o.yaw;                  // 0..65535 covers a full turn
        up    = (o.pitch >= PITCH_UP_DEF);
        if (yaw_u < 16'h4000) begin
            return up ? CODE_CRASH : CODE_SNARE;
        end else if (yaw_u < 16'h8000) begin
            return up ? CODE_RIDE : CODE_HI_TOM;
        end else if (yaw_u < 16'hC000) begin
            return CODE_FLOOR_TOM;
        end
        return (rate_z >= 0) ? CODE_HAT_OPEN : CODE_HAT_CLOSED;
    endfunction

    // All stimulus tasks start and end just after a falling edge
    task automatic send_orient(input angle_t yaw, input angle_t pitch, input logic cal);
        orient_valid    = 1'b1;
        orient.yaw      = yaw;
        orient.pitch    = pitch;
        calibrate_pulse = cal;
        if (cal) begin
            yaw_zero = yaw;
        end
        held.yaw   = angle_t'(yaw - yaw_zero); // Wraps like the sensor angle
        held.pitch = pitch;
        @(negedge clk);
        orient_valid    = 1'b0;
        calibrate_pulse = 1'b0;
        @(negedge clk); // Classifier takes the rebased sample
    endtask

    task automatic drive_gyro(input rate_t rate_y, input rate_t rate_z);
        gyro_valid  = 1'b1;
        gyro.rate_y = rate_y;
        gyro.rate_z = rate_z;
    endtask

    task automatic rearm(input string test);
        drive_gyro(REARM_RATE, 16'sd0);
        @(negedge clk);
        gyro_valid = 1'b0;
        check_flag(test, 1'b0, trigger_valid); // Trigger is a single pulse
        @(negedge clk);
    endtask

    // Trigger must show up exactly HIT_LATENCY cycles after the strike sample
    task automatic strike_and_check(input string test, input rate_t rate_z);
        drum_code_t exp;
        exp = expected_code(held, rate_z);
        drive_gyro(STRIKE_RATE, rate_z);
        for (int i = 1; i <= HIT_LATENCY; i++) begin
            @(negedge clk);
            gyro_valid = 1'b0;
            if (i < HIT_LATENCY) begin
                check_flag(test, 1'b0, trigger_valid); // Too early
            end
        end
        check_flag(test, 1'b1, trigger_valid);
        check_code(test, exp, trigger_code);
        rearm(test);
    endtask

    task automatic count_triggers(input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(negedge clk);
            gyro_valid = 1'b0;
            if (trigger_valid) begin
                n++;
            end
        end
    endtask

    task automatic reset_state();
        check_flag("reset_trigger_valid", 1'b0, trigger_valid);
        check_flag("reset_event_dropped", 1'b0, event_dropped);
        strike_and_check("reset_first_strike", rate_t'(random16())); // Zero orientation, snare
    endtask

    task automatic classify_random();
        for (int k = 0; k < 20; k++) begin
            send_orient(angle_t'(random16()), angle_t'(random16()), 1'b0);
            strike_and_check($sformatf("classify_%0d", k), rate_t'(random16()));
        end
    endtask

    task automatic calibration_wrap();
        angle_t y;
        angle_t y2;
        y = angle_t'(random16());
        send_orient(y, 16'sd0, 1'b1);
        strike_and_check("cal_sample_zero", rate_t'(random16()));
        send_orient(angle_t'(y + 16'sd16384), 16'sd0, 1'b0); // Quarter turn, zone 1
        strike_and_check("cal_quarter_turn", rate_t'(random16()));
        send_orient(angle_t'(y - 16'sd1), PITCH_UP_DEF, 1'b0); // Wraps into zone 3
        strike_and_check("cal_wrap_below", -16'sd200);
        strike_and_check("cal_wrap_below_twist", 16'sd200);
        // Button between samples, next sample becomes the zero
        calibrate_pulse = 1'b1;
        @(negedge clk);
        calibrate_pulse = 1'b0;
        @(negedge clk);
        y2       = angle_t'(random16());
        yaw_zero = y2;
        send_orient(y2, PITCH_UP_DEF, 1'b0);
        strike_and_check("cal_pending_zero", rate_t'(random16()));
        send_orient(angle_t'(y2 ^ 16'h8000), 16'sd0, 1'b0); // Half turn, floor tom
        strike_and_check("cal_pending_half_turn", rate_t'(random16()));
    endtask

    task automatic strike_hysteresis();
        int    n;
        rate_t rz;
        rz = rate_t'(random16());
        repeat (3) begin
            drive_gyro(STRIKE_RATE, rz);
            @(negedge clk);
        end
        gyro_valid = 1'b0;
        count_triggers(8, n);
        check_count("hysteresis_one_per_swing", 1, n);
        drive_gyro(16'sd0, rz); // Equal to the re-arm threshold, not above
        @(negedge clk);
        drive_gyro(STRIKE_RATE, rz);
        count_triggers(8, n);
        check_count("hysteresis_no_rearm", 0, n);
        rearm("hysteresis_rearm");
        strike_and_check("hysteresis_second_swing", rz);
    endtask

    task automatic single_kick();
        kick_pulse = 1'b1;
        @(negedge clk);
        kick_pulse = 1'b0;
        check_flag("single_kick_valid", 1'b1, trigger_valid);
        check_code("single_kick_code", CODE_KICK, trigger_code);
        @(negedge clk);
        check_flag("single_kick_once", 1'b0, trigger_valid);
    endtask

    // Kick held 12 cycles while strikes land, hits drain afterwards in order
    task automatic kick_burst(input string test, input int strikes, input bit dropped);
        drum_code_t exp_q[$];
        rate_t      rz_q[$];
        rate_t      rz;
        int         i;
        int         n;
        send_orient(angle_t'(yaw_zero - 16'sd1), 16'sd0, 1'b0); // Zone 3, twist picks the hat
        for (int k = 0; k < 12; k++) begin
            exp_q.push_back(CODE_KICK);
        end
        for (int k = 0; k < strikes; k++) begin
            rz = rate_t'(random16());
            rz[15] = k[0]; // Open and closed hats alternate, so order is visible
            rz_q.push_back(rz);
            if (k < 4) begin
                exp_q.push_back(expected_code(held, rz)); // FIFO holds four
            end
        end
        i = 0;
        while (exp_q.size() > 0) begin
            kick_pulse = (i < 12);
            if (i < 2 * strikes - 1) begin
                if (i % 2 == 0) begin
                    drive_gyro(STRIKE_RATE, rz_q.pop_front());
                end else begin
                    drive_gyro(REARM_RATE, 16'sd0);
                end
            end else begin
                gyro_valid = 1'b0;
            end
            @(negedge clk);
            i++;
            if (trigger_valid) begin
                check_code($sformatf("%s_trigger_%0d", test, i), exp_q.pop_front(), trigger_code);
            end
            if (i > 40) begin
                stop_on_error($sformatf("%s: %0d triggers never arrived", test, exp_q.size()));
            end
        end
        kick_pulse = 1'b0;
        gyro_valid = 1'b0;
        count_triggers(6, n);
        check_count($sformatf("%s_no_extra", test), 0, n);
        check_flag($sformatf("%s_dropped", test), dropped, event_dropped);
        rearm(test);
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        orient_valid    = 1'b0;
        orient          = '0;
        gyro_valid      = 1'b0;
        gyro            = '0;
        calibrate_pulse = 1'b0;
        kick_pulse      = 1'b0;
        rng_state       = 32'h2d17d44c;
        yaw_zero        = '0;
        held            = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_state();
        classify_random();
        calibration_wrap();
        strike_hysteresis();
        single_kick();
        kick_burst("burst_three", 3, 1'b0);
        kick_burst("burst_five", 5, 1'b1); // Fifth hit overflows
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== drum_trigger.f ====
logic/drum_geom_pkg.sv
logic/drum_event_pkg.sv
logic/yaw_normalizer.sv
logic/strike_detector.sv
logic/hit_classifier.sv
logic/event_fifo.sv
logic/trigger_arbiter.sv
logic/drum_trigger_top.sv
bench/drum_trigger_tb.sv

// ==== logic/drum_event_pkg.sv ====
package drum_event_pkg;

    // Quadrant of the normalized yaw, 90 degrees each
    typedef logic [1:0] zone_t;

    // Drum code as sent to the sound module
    typedef logic [3:0] drum_code_t;

    localparam drum_code_t CODE_SNARE      = 4'd0;
    localparam drum_code_t CODE_HI_TOM     = 4'd1;
    localparam drum_code_t CODE_KICK       = 4'd2; // Only from the kick button
    localparam drum_code_t CODE_FLOOR_TOM  = 4'd3;
    localparam drum_code_t CODE_CRASH      = 4'd4;
    localparam drum_code_t CODE_RIDE       = 4'd5;
    localparam drum_code_t CODE_HAT_OPEN   = 4'd6;
    localparam drum_code_t CODE_HAT_CLOSED = 4'd7;

    // One classified stick hit, as stored in the event FIFO
    typedef struct packed {
        zone_t      zone; // Kept for debug and event tracing
        drum_code_t code;
    } hit_event_t;

endpackage

// ==== logic/drum_geom_pkg.sv ====
package drum_geom_pkg;

    // Binary angle, -32768..32767 covers -180..+180 degrees
    // Wrap-around is plain 16-bit overflow
    typedef logic signed [15:0] angle_t;

    // Gyro rate in raw sensor counts
    typedef logic signed [15:0] rate_t;

    // Orientation sample from the sensor fusion output
    typedef struct packed {
        angle_t yaw;   // Heading, rebased after calibration
        angle_t pitch; // Stick elevation
    } orient_t;

    // Gyro sample, only the two axes the trigger logic looks at
    typedef struct packed {
        rate_t rate_y; // Swing axis, strongly negative on a downstroke
        rate_t rate_z; // Twist axis, sign picks open or closed hat
    } gyro_t;

    // Strike fires below this y-rate
    localparam rate_t STRIKE_THRESH_DEF = -16'sd2500;

    // Detector re-arms above this y-rate
    localparam rate_t REARM_THRESH_DEF = 16'sd0;

    // About 22.5 degrees of pitch counts as "up"
    localparam angle_t PITCH_UP_DEF = 16'sd4096;

endpackage

// ==== logic/drum_trigger_top.sv ====
module drum_trigger_top #(
    parameter drum_geom_pkg::rate_t  STRIKE_THRESH = drum_geom_pkg::STRIKE_THRESH_DEF,
    parameter drum_geom_pkg::rate_t  REARM_THRESH  = drum_geom_pkg::REARM_THRESH_DEF,
    parameter drum_geom_pkg::angle_t PITCH_UP      = drum_geom_pkg::PITCH_UP_DEF,
    parameter int                    FIFO_DEPTH    = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Sensor side
    input  logic                       orient_valid,
    input  drum_geom_pkg::orient_t     orient,
    input  logic                       gyro_valid,
    input  drum_geom_pkg::gyro_t       gyro,
    // Buttons, one-cycle pulses
    input  logic                       calibrate_pulse,
    input  logic                       kick_pulse,
    // Sound module side
    output logic                       trigger_valid,
    output drum_event_pkg::drum_code_t trigger_code,
    output logic                       event_dropped
);
    import drum_geom_pkg::*;
    import drum_event_pkg::*;

    logic       norm_valid;
    orient_t    norm_orient; // Yaw relative to the calibrated zero
    logic       strike;
    logic       push;
    hit_event_t push_event;
    hit_event_t head;
    logic       not_empty;
    logic       pop;

    yaw_normalizer u_yaw_normalizer (
        .clk             (clk),
        .rst_n           (rst_n),
        .orient_valid    (orient_valid),
        .orient          (orient),
        .calibrate_pulse (calibrate_pulse),
        .norm_valid      (norm_valid),
        .norm_orient     (norm_orient)
    );

    strike_detector #(
        .STRIKE_THRESH (STRIKE_THRESH),
        .REARM_THRESH  (REARM_THRESH)
    ) u_strike_detector (
        .clk        (clk),
        .rst_n      (rst_n),
        .gyro_valid (gyro_valid),
        .rate_y     (gyro.rate_y),
        .strike     (strike)
    );

    // Producer, turns a strike into a hit event
    hit_classifier #(
        .PITCH_UP (PITCH_UP)
    ) u_hit_classifier (
        .clk         (clk),
        .rst_n       (rst_n),
        .norm_valid  (norm_valid),
        .norm_orient (norm_orient),
        .strike      (strike),
        .rate_z      (gyro.rate_z), // Realigned to the strike inside
        .push        (push),
        .push_event  (push_event)
    );

    // Buffer, absorbs hits while kicks hold the output
    event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_event_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_event    (push_event),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .event_dropped (event_dropped)
    );

    // Consumer
    trigger_arbiter u_trigger_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .kick_pulse    (kick_pulse),
        .not_empty     (not_empty),
        .head          (head),
        .pop           (pop),
        .trigger_valid (trigger_valid),
        .trigger_code  (trigger_code)
    );

endmodule

// ==== logic/event_fifo.sv ====
module event_fifo #(
    parameter int FIFO_DEPTH = 4 // Power of two, at least 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,          // Write strobe
    input  drum_event_pkg::hit_event_t push_event,
    input  logic                       pop,           // Read strobe, head is consumed
    output drum_event_pkg::hit_event_t head,          // Show-ahead output
    output logic                       not_empty,
    output logic                       event_dropped  // Sticky overflow flag
);
    import drum_event_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = FIFO_DEPTH[AW:0];

    hit_event_t    mem [FIFO_DEPTH]; // Event storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;            // Occupancy, one bit wider than the pointers
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full      = (count == FULL_COUNT);
    assign not_empty = (count != '0);
    assign do_push   = push & ~full;      // Full FIFO discards, even with a pop
    assign do_pop    = pop & not_empty;

    // Pointers, count and drop flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            event_dropped <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither, level unchanged
            endcase
            if (push && full) begin
                event_dropped <= 1'b1; // Cleared by reset only
            end
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_event;
        end
    end

    assign head = mem[rd_ptr]; // Visible the cycle after its push

    // The arbiter must look at not_empty before popping
    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty)
        else $error("pop from an empty event FIFO");

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= FULL_COUNT)
        else $error("event FIFO count above depth");

endmodule

// ==== logic/hit_classifier.sv ====
module hit_classifier #(
    parameter drum_geom_pkg::angle_t PITCH_UP = drum_geom_pkg::PITCH_UP_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        norm_valid,  // Rebased orientation strobe
    input  drum_geom_pkg::orient_t      norm_orient,
    input  logic                        strike,      // One cycle after the gyro sample
    input  drum_geom_pkg::rate_t        rate_z,      // Live gyro z-rate
    output logic                        push,        // FIFO write strobe
    output drum_event_pkg::hit_event_t  push_event
);
    import drum_geom_pkg::*;
    import drum_event_pkg::*;

    orient_t    held_orient; // Latest stick orientation
    rate_t      rate_z_q;    // z-rate of the sample that raised strike
    zone_t      zone;
    logic       pitch_up;
    logic       hat_open;
    drum_code_t code;

    // Orientation is sticky, zero until the first sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_orient <= '0;
        end else if (norm_valid) begin
            held_orient <= norm_orient;
        end
    end

    // strike lags its gyro sample by one cycle, so one stage realigns rate_z
    always_ff @(posedge clk) begin
        rate_z_q <= rate_z;
    end

    assign zone     = held_orient.yaw[15:14];     // Top two bits give the quadrant
    assign pitch_up = (held_orient.pitch >= PITCH_UP);
    assign hat_open = ~rate_z_q[15];              // Sign bit clear, rate_z >= 0

    // Drum map
    always_comb begin
        case (zone)
            2'd0:    code = pitch_up ? CODE_CRASH : CODE_SNARE;
            2'd1:    code = pitch_up ? CODE_RIDE : CODE_HI_TOM;
            2'd2:    code = CODE_FLOOR_TOM;            // Pitch ignored
            default: code = hat_open ? CODE_HAT_OPEN : CODE_HAT_CLOSED;
        endcase
    end

    // Push strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= strike;
        end
    end

    // Event payload, meaningful only with push
    always_ff @(posedge clk) begin
        if (strike) begin
            push_event.zone <= zone;
            push_event.code <= code;
        end
    end

    // Kick comes only from the button path
    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (push_event.code != CODE_KICK))
        else $error("classifier pushed a kick code");

endmodule

// ==== logic/strike_detector.sv ====
module strike_detector #(
    parameter drum_geom_pkg::rate_t STRIKE_THRESH = drum_geom_pkg::STRIKE_THRESH_DEF,
    parameter drum_geom_pkg::rate_t REARM_THRESH  = drum_geom_pkg::REARM_THRESH_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 gyro_valid, // Gyro sample strobe
    input  drum_geom_pkg::rate_t rate_y,     // Swing axis rate
    output logic                 strike      // One cycle per downward swing
);

    // ARMED waits for a downstroke, STRUCK waits for the stick to come back up
    typedef enum logic {
        ARMED,
        STRUCK
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ARMED;
            strike <= 1'b0;
        end else begin
            strike <= 1'b0; // Pulse by default
            if (gyro_valid) begin
                case (state)
                    ARMED: begin
                        if (rate_y < STRIKE_THRESH) begin
                            state  <= STRUCK;
                            strike <= 1'b1;
                        end
                    end
                    STRUCK: begin
                        // Gap between the two thresholds is the hysteresis band
                        if (rate_y > REARM_THRESH) begin
                            state <= ARMED;
                        end
                    end
                    default: state <= ARMED;
                endcase
            end
        end
    end

    // One strike per swing, never a held level
    assert property (@(posedge clk) disable iff (!rst_n)
        strike |=> !strike)
        else $error("strike held high for two cycles");

endmodule

// ==== logic/trigger_arbiter.sv ====
module trigger_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       kick_pulse,    // Kick button
    input  logic                       not_empty,     // FIFO has a hit waiting
    input  drum_event_pkg::hit_event_t head,
    output logic                       pop,
    output logic                       trigger_valid,
    output drum_event_pkg::drum_code_t trigger_code   // Valid with trigger_valid only
);
    import drum_event_pkg::*;

    // Kick wins the slot, a waiting hit stays at the head for a later cycle
    assign pop = ~kick_pulse & not_empty;

    // Trigger strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trigger_valid <= 1'b0;
        end else begin
            trigger_valid <= kick_pulse | not_empty; // At most one trigger per cycle
        end
    end

    // Trigger code
    always_ff @(posedge clk) begin
        if (kick_pulse) begin
            trigger_code <= CODE_KICK;
        end else if (not_empty) begin
            trigger_code <= head.code;
        end
    end

endmodule

// ==== logic/yaw_normalizer.sv ====
module yaw_normalizer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   orient_valid,    // Orientation sample strobe
    input  drum_geom_pkg::orient_t orient,
    input  logic                   calibrate_pulse, // Button, sets yaw zero
    output logic                   norm_valid,
    output drum_geom_pkg::orient_t norm_orient      // Valid with norm_valid only
);
    import drum_geom_pkg::*;

    angle_t yaw_offset;  // Yaw that maps to zero
    logic   cal_pending; // Button seen between samples
    logic   cal_now;     // Calibrate on this sample

    // A pending request is served by the next orientation sample
    assign cal_now = calibrate_pulse | cal_pending;

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            yaw_offset  <= '0; // No rebasing until first calibration
            cal_pending <= 1'b0;
            norm_valid  <= 1'b0;
        end else begin
            norm_valid <= orient_valid;
            if (orient_valid) begin
                if (cal_now) begin
                    yaw_offset  <= orient.yaw;
                    cal_pending <= 1'b0;
                end
            end else if (calibrate_pulse) begin
                cal_pending <= 1'b1; // Hold until a sample arrives
            end
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (orient_valid) begin
            // Calibration sample itself reads as straight ahead
            // Subtraction wraps mod 2^16, same as angle wrap
            norm_orient.yaw   <= cal_now ? angle_t'(0) : angle_t'(orient.yaw - yaw_offset);
            norm_orient.pitch <= orient.pitch; // Pitch is not rebased
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the drum trigger testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module drum_trigger_tb -f drum_trigger.f > sim.log 2>&1 \
    && ./obj_dir/Vdrum_trigger_tb >> sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
